// File: Bender.yml
package:
  name: core6809

sources:
  - src/cpu6809_pkg.sv
  - src/fetch_sequencer.sv
  - src/program_counter.sv
  - src/load_store_unit.sv
  - src/accumulator_alu.sv
  - src/core6809.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/core6809_properties.sv
      - sim/core6809_tb.sv

// File: sim/core6809_properties.sv
/* Concurrent checks on the write strobe, bus ownership and FSM states of the
   core; bound into core6809 by the testbench */
`timescale 1ns/1ps
`default_nettype none

module core6809_properties
  import cpu6809_pkg::*;
(
  input logic              clk,
  input logic              reset_b,
  input logic              data_rw_n,
  input logic              lsu_busy,
  input lsu_state_e        lsu_state,
  input fetch_state_e      fetch_state,
  input logic [data_w-1:0] cc
);

  // Write only from the LSU store state, which owns the bus
  write_only_in_store: assert property (
    @(posedge clk) disable iff (!reset_b)
    !data_rw_n |-> (lsu_state == lsu_store) && lsu_busy
  ) else $error("write strobe low outside the LSU store state");

  // Fetch FSM only steps along its legal edges
  fetch_state_legal: assert property (
    @(posedge clk) disable iff (!reset_b)
    !$isunknown(fetch_state) &&
    ((fetch_state != fetch_b1) || ($past(fetch_state) == fetch_ir)) &&
    ((fetch_state != fetch_b2) || ($past(fetch_state) == fetch_b1)) &&
    ((fetch_state != fetch_wait) || ($past(fetch_state) inside {fetch_wait, fetch_b2}))
  ) else $error("fetch state is unknown or took an illegal transition");

  // Fetch holds off while the LSU has the bus
  fetch_waits_for_bus: assert property (
    @(posedge clk) disable iff (!reset_b)
    (lsu_busy && (fetch_state == fetch_wait)) |=> (fetch_state == fetch_wait)
  ) else $error("fetch left its wait state while the LSU held the bus");

  // First edge out of reset, read cycle and CC at its reset value
  reset_exit_state: assert property (
    @(posedge clk)
    $rose(reset_b) |-> data_rw_n && (cc == cc_reset)
  ) else $error("bus or CC not in reset state after reset release");

endmodule

`default_nettype wire

// File: sim/core6809_tb.sv
/* Self-checking testbench for the core slice; builds a table of small programs,
   runs each one from reset and checks every bus write against the table */
`timescale 1ns/1ps
`default_nettype none

module core6809_tb
  import cpu6809_pkg::*;
();

  localparam int n_rows    = 19;
  localparam int img_max   = 48;
  localparam int wr_max    = 8;
  localparam int run_limit = 400;   // Cycles per program

  logic              clk;
  logic              reset_b;
  logic [data_w-1:0] data_in;
  logic [addr_w-1:0] addr;
  logic              data_rw_n;
  logic [data_w-1:0] data_out;

  logic [7:0] mem [0:65535];

  // Program table, one row per test
  string       row_name [0:n_rows-1];
  logic [15:0] row_vec  [0:n_rows-1];
  logic [15:0] row_end  [0:n_rows-1];   // Address of the closing BCC
  int          row_len  [0:n_rows-1];
  logic [7:0]  row_img  [0:n_rows-1][0:img_max-1];
  int          exp_cnt  [0:n_rows-1];
  logic [15:0] exp_addr [0:n_rows-1][0:wr_max-1];
  logic [7:0]  exp_data [0:n_rows-1][0:wr_max-1];

  int          cur;    // Row being built
  logic [31:0] rng;

  tb_clock #(.period_ns(4.0)) tb_clock_inst (.clk(clk));

  core6809 core6809_inst (
    .clk       (clk),
    .reset_b   (reset_b),
    .data_in   (data_in),
    .addr      (addr),
    .data_rw_n (data_rw_n),
    .data_out  (data_out)
  );

  bind core6809 core6809_properties core6809_properties_inst (
    .clk         (clk),
    .reset_b     (reset_b),
    .data_rw_n   (data_rw_n),
    .lsu_busy    (lsu_busy),
    .lsu_state   (load_store_unit_inst.state_q),
    .fetch_state (fetch_sequencer_inst.state_q),
    .cc          (accumulator_alu_inst.cc_q)
  );

  // --------------------------------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Kinds 0..7 are CLR INC ASL ROL ASR LSR ROR COM; carry out in bit 8
  function automatic logic [8:0] model_inherent(input int kind, input logic [7:0] v,
                                                input logic cin);
    logic [8:0] r;
    case (kind)
      0:       r = 9'h000;
      1:       r = {1'b0, v} + 9'd1;
      2:       r = {v[7], v[6:0], 1'b0};
      3:       r = {v[7], v[6:0], cin};
      4:       r = {v[0], v[7], v[7:1]};
      5:       r = {v[0], 1'b0, v[7:1]};
      6:       r = {v[0], cin, v[7:1]};
      default: r = {1'b1, ~v};
    endcase
    return r;
  endfunction

  // B forms sit 0x10 above the A forms
  function automatic logic [7:0] inherent_opcode(input int kind, input logic on_b);
    logic [7:0] op;
    case (kind)
      0:       op = 8'h4f;
      1:       op = 8'h4c;
      2:       op = 8'h48;
      3:       op = 8'h49;
      4:       op = 8'h47;
      5:       op = 8'h44;
      6:       op = 8'h46;
      default: op = 8'h43;
    endcase
    return on_b ? op + 8'h10 : op;
  endfunction

  function automatic string kind_name(input int kind);
    string s;
    case (kind)
      0:       s = "clr";
      1:       s = "inc";
      2:       s = "asl";
      3:       s = "rol";
      4:       s = "asr";
      5:       s = "lsr";
      6:       s = "ror";
      default: s = "com";
    endcase
    return s;
  endfunction

  task automatic stop_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [15:0] expected, input logic [15:0] actual);
    assert (expected === actual) else begin
      $display("[ERROR] %s: %s expected %h actual %h", test, what, expected, actual);
      stop_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // Table building
  // --------------------------------------------------------------------------
  task automatic start_row(input string name, input logic [15:0] vec);
    row_name[cur] = name;
    row_vec[cur]  = vec;
    row_len[cur]  = 0;
    exp_cnt[cur]  = 0;
  endtask

  task automatic put(input logic [7:0] b);
    row_img[cur][row_len[cur]] = b;
    row_len[cur] = row_len[cur] + 1;
  endtask

  // Opcode with a big-endian extended address or 16-bit immediate
  task automatic put3(input logic [7:0] op, input logic [15:0] w);
    put(op);
    put(w[15:8]);
    put(w[7:0]);
  endtask

  task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
    exp_addr[cur][exp_cnt[cur]] = a;
    exp_data[cur][exp_cnt[cur]] = d;
    exp_cnt[cur] = exp_cnt[cur] + 1;
  endtask

  // CLRA clears C, then BCC back onto itself
  task automatic end_row();
    put(8'h4f);
    row_end[cur] = row_vec[cur] + 16'(row_len[cur]);
    put(8'h24);
    put(8'hfe);
    cur = cur + 1;
  endtask

  task automatic build_table();
    logic [7:0]  v;
    logic [8:0]  r;
    logic        cin;
    logic        on_b;
    logic [15:0] ea;
    cur = 0;
    // Immediate loads, extended stores, vector away from page zero
    start_row("load_store", 16'hc5a0);
    put(8'h86);
    put(8'h5a);
    put3(8'hb7, 16'h2000);
    put(8'hc6);
    put(8'ha5);
    put3(8'hf7, 16'h2001);
    put3(8'hb7, 16'h2002);
    expect_write(16'h2000, 8'h5a);
    expect_write(16'h2001, 8'ha5);
    expect_write(16'h2002, 8'h5a);
    end_row();
    // Each inherent op on a random byte, carry in set by COM on the other reg
    for (int k = 0; k < 16; k++) begin
      rng  = xorshift32(rng);
      v    = rng[7:0];
      cin  = rng[8];
      on_b = (k >= 8);
      r    = model_inherent(k % 8, v, cin);
      ea   = 16'h3000 + 16'(2 * k);
      start_row({kind_name(k % 8), on_b ? "b" : "a"}, 16'h0400 + (16'(k) << 8));
      if (cin) begin
        put(on_b ? 8'h43 : 8'h53);
      end
      put(on_b ? 8'hc6 : 8'h86);
      put(v);
      put(inherent_opcode(k % 8, on_b));
      put3(on_b ? 8'hf7 : 8'hb7, ea);
      expect_write(ea, r[7:0]);
      // Second copy only lands when C came out clear
      put(8'h25);
      put(8'h03);
      put3(on_b ? 8'hf7 : 8'hb7, ea + 16'd1);
      if (!r[8]) begin
        expect_write(ea + 16'd1, r[7:0]);
      end
      end_row();
    end
    // 16-bit immediate, high byte to A
    start_row("ldd", 16'h8000);
    put3(8'hcc, 16'hbeef);
    put3(8'hb7, 16'h4000);
    put3(8'hf7, 16'h4001);
    expect_write(16'h4000, 8'hbe);
    expect_write(16'h4001, 8'hef);
    end_row();
    // BCS and BCC over stores, then INCB count-up loop with offset FA
    start_row("branches", 16'h9000);
    put(8'h86);
    put(8'h81);
    put(8'h48);
    put(8'h25);
    put(8'h03);
    put3(8'hb7, 16'h5000);
    put3(8'hb7, 16'h5001);
    put(8'h44);
    put(8'h24);
    put(8'h03);
    put3(8'hb7, 16'h5002);
    put3(8'hb7, 16'h5003);
    put(8'hc6);
    put(8'hfd);
    put(8'h5c);
    put3(8'hf7, 16'h6000);
    put(8'h24);
    put(8'hfa);
    expect_write(16'h5001, 8'h02);
    expect_write(16'h5003, 8'h01);
    expect_write(16'h6000, 8'hfe);
    expect_write(16'h6000, 8'hff);
    expect_write(16'h6000, 8'h00);
    end_row();
  endtask

  // --------------------------------------------------------------------------
  // Running one row
  // --------------------------------------------------------------------------
  task automatic run_row(input int row);
    int          cycle;
    int          end_hits;
    int          wr_idx;
    logic [15:0] a;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = i[15:8] ^ i[7:0];
    end
    for (int i = 0; i < row_len[row]; i++) begin
      a = row_vec[row] + 16'(i);
      mem[a] = row_img[row][i];
    end
    mem[reset_vector_addr]         = row_vec[row][15:8];
    mem[reset_vector_addr + 16'd1] = row_vec[row][7:0];

    @(negedge clk);
    reset_b = 1'b0;
    repeat (2) @(negedge clk);
    reset_b  = 1'b1;
    cycle    = 0;
    end_hits = 0;
    wr_idx   = 0;
    // Two visits to the closing BCC mean the end loop closed
    while (end_hits < 2) begin
      data_in = mem[addr];
      case (cycle)
        0:       check_value(row_name[row], "vector high address", reset_vector_addr, addr);
        1:       check_value(row_name[row], "vector low address",
                             reset_vector_addr + 16'd1, addr);
        3:       check_value(row_name[row], "first opcode address", row_vec[row], addr);
        default: ;
      endcase
      if (!data_rw_n) begin
        assert (wr_idx < exp_cnt[row]) else begin
          $display("%s: unexpected write of %h to address %h", row_name[row], data_out, addr);
          stop_run();
        end
        check_value(row_name[row], $sformatf("write %0d address", wr_idx),
                    exp_addr[row][wr_idx], addr);
        check_value(row_name[row], $sformatf("write %0d data", wr_idx),
                    {8'h00, exp_data[row][wr_idx]}, {8'h00, data_out});
        wr_idx = wr_idx + 1;
      end
      if ((addr == row_end[row]) && data_rw_n) begin
        end_hits = end_hits + 1;
      end
      cycle = cycle + 1;
      assert (cycle < run_limit) else begin
        $display("%s: core did not reach its end address within %0d cycles",
                 row_name[row], run_limit);
        stop_run();
      end
      @(negedge clk);
    end
    check_value(row_name[row], "write count", 16'(exp_cnt[row]), 16'(wr_idx));
  endtask

  initial begin
    reset_b = 1'b0;
    data_in = '0;
    rng     = 32'h630a_9d61;
    build_table();
    for (int row = 0; row < n_rows; row++) begin
      run_row(row);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
/* Free-running testbench clock, 4 ns period unless overridden */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real period_ns = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // One phase per half period
  always begin
    #(period_ns / 2.0);
    clk = ~clk;
  end

endmodule

`default_nettype wire

// File: sources.f
src/cpu6809_pkg.sv
src/fetch_sequencer.sv
src/program_counter.sv
src/load_store_unit.sv
src/accumulator_alu.sv
src/core6809.sv
sim/tb_clock.sv
sim/core6809_properties.sv
sim/core6809_tb.sv

// File: src/accumulator_alu.sv
/* 8-bit ALU with N, Z, V and C flag logic and the A, B and CC registers;
   applies one operation on each exec_strobe from the fetch sequencer */
`timescale 1ns/1ps
`default_nettype none

module accumulator_alu
  import cpu6809_pkg::*;
(
  input  logic              clk,
  input  logic              reset_b,
  input  logic              exec_strobe,
  input  opcode_e           opcode,
  input  logic [data_w-1:0] operand_hi,
  input  logic [data_w-1:0] operand_lo,
  output logic [data_w-1:0] a_q,
  output logic [data_w-1:0] b_q,
  output logic              cc_c
);

  logic [data_w-1:0] cc_q;
  logic [data_w-1:0] cc_nxt;
  logic              carry_in;
  logic              grp_a;       // Inherent op on A
  logic              grp_b;       // Inherent op on B
  logic [data_w-1:0] src;
  logic [data_w:0]   inc_sum;
  logic [data_w-1:0] res;
  logic              res_c;
  logic              res_v;
  logic              res_z;
  logic              is_shift;
  logic              wr_a;
  logic              wr_b;
  logic              wr_cc;

  // Port name hides the package offset here
  assign carry_in = cc_q[cpu6809_pkg::cc_c];
  assign cc_c     = carry_in;

  // --------------------------------------------------------------------------
  // Source select
  // --------------------------------------------------------------------------
  assign grp_a = opcode inside {op_clra, op_inca, op_asla, op_rola,
                                op_asra, op_lsra, op_rora, op_coma};
  assign grp_b = opcode inside {op_clrb, op_incb, op_aslb, op_rolb,
                                op_asrb, op_lsrb, op_rorb, op_comb};

  assign src     = grp_b ? b_q : a_q;
  assign inc_sum = src + 1'b1;

  // --------------------------------------------------------------------------
  // Result and flags
  // --------------------------------------------------------------------------
  always_comb begin
    res      = src;
    res_c    = carry_in;
    res_v    = 1'b0;
    is_shift = 1'b0;
    wr_cc    = 1'b1;
    case (opcode)
      op_clra, op_clrb: begin
        res   = '0;
        res_c = 1'b0;
      end
      op_inca, op_incb: begin
        res   = inc_sum[data_w-1:0];
        res_c = inc_sum[data_w];
        res_v = (src == 8'h7f);   // Only 7F to 80 overflows
      end
      op_asla, op_aslb: begin
        res      = {src[data_w-2:0], 1'b0};
        res_c    = src[data_w-1];
        is_shift = 1'b1;
      end
      op_rola, op_rolb: begin
        res      = {src[data_w-2:0], carry_in};
        res_c    = src[data_w-1];
        is_shift = 1'b1;
      end
      op_asra, op_asrb: begin
        res      = {src[data_w-1], src[data_w-1:1]};
        res_c    = src[0];
        is_shift = 1'b1;
      end
      op_lsra, op_lsrb: begin
        res      = {1'b0, src[data_w-1:1]};
        res_c    = src[0];
        is_shift = 1'b1;
      end
      op_rora, op_rorb: begin
        res      = {carry_in, src[data_w-1:1]};
        res_c    = src[0];
        is_shift = 1'b1;
      end
      op_coma, op_comb: begin
        res   = ~src;
        res_c = 1'b1;
      end
      // Loads pass the operand through, carry held
      op_lda, op_ldb, op_ldd: res = operand_hi;
      // Stores, branches and illegal leave CC alone
      default: wr_cc = 1'b0;
    endcase
    if (is_shift) begin
      res_v = res[data_w-1] ^ res_c;
    end
  end

  // LDD tests the whole 16-bit value for zero
  assign res_z = (opcode == op_ldd) ? ~|{operand_hi, operand_lo} : ~|res;

  always_comb begin
    cc_nxt       = cc_q;
    cc_nxt[cc_n] = res[data_w-1];
    cc_nxt[cc_z] = res_z;
    cc_nxt[cc_v] = res_v;
    cc_nxt[cpu6809_pkg::cc_c] = res_c;
    // Half carry is not defined by any op here
    cc_nxt[cc_h] = cc_q[cc_h];
  end

  assign wr_a = grp_a || (opcode inside {op_lda, op_ldd});
  assign wr_b = grp_b || (opcode inside {op_ldb, op_ldd});

  // --------------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a_q  <= '0;
      b_q  <= '0;
      cc_q <= cc_reset;
    end else if (exec_strobe) begin
      if (wr_a) a_q <= res;
      if (wr_b) b_q <= (opcode == op_ldd) ? operand_lo : res;
      if (wr_cc) cc_q <= cc_nxt;
    end
  end

endmodule

`default_nettype wire

// File: src/core6809.sv
/* Top of the 6809-style core slice; connects fetch, program counter, ALU
   and load/store unit to a combinational byte-wide memory bus */
`timescale 1ns/1ps
`default_nettype none

module core6809
  import cpu6809_pkg::*;
(
  input  logic              clk,
  input  logic              reset_b,
  input  logic [data_w-1:0] data_in,
  output logic [addr_w-1:0] addr,
  output logic              data_rw_n,
  output logic [data_w-1:0] data_out
);

  // Fetch to the other units
  logic              pc_inc;
  logic              branch_taken;
  logic [data_w-1:0] offset;
  logic              exec_strobe;
  opcode_e           opcode;
  logic [data_w-1:0] operand_hi;
  logic [data_w-1:0] operand_lo;
  logic              store_req;
  logic [addr_w-1:0] store_addr;
  logic              store_sel;

  // Registers and bus ownership
  logic [addr_w-1:0] pc;
  logic [data_w-1:0] a_q;
  logic [data_w-1:0] b_q;
  logic              cc_c;
  logic              lsu_busy;
  logic [addr_w-1:0] lsu_addr;
  logic              vec_load;
  logic [addr_w-1:0] vec_value;

  // --------------------------------------------------------------------------
  // Units
  // --------------------------------------------------------------------------
  fetch_sequencer fetch_sequencer_inst (
    .clk, .reset_b, .data_in, .lsu_busy, .cc_c,
    .pc_inc, .branch_taken, .offset,
    .exec_strobe, .opcode, .operand_hi, .operand_lo,
    .store_req, .store_addr, .store_sel
  );

  program_counter program_counter_inst (
    .clk, .reset_b, .pc_inc, .branch_taken, .offset, .vec_load, .vec_value, .pc
  );

  accumulator_alu accumulator_alu_inst (
    .clk, .reset_b, .exec_strobe, .opcode, .operand_hi, .operand_lo,
    .a_q, .b_q, .cc_c
  );

  load_store_unit #(
    .reset_vector_addr_p (reset_vector_addr)
  ) load_store_unit_inst (
    .clk, .reset_b, .data_in, .store_req, .store_addr, .store_sel, .a_q, .b_q,
    .lsu_busy, .lsu_addr, .data_rw_n, .data_out, .vec_load, .vec_value
  );

  // Instruction fetch owns the bus unless the LSU is busy
  assign addr = lsu_busy ? lsu_addr : pc;

endmodule

`default_nettype wire

// File: src/cpu6809_pkg.sv
/* Widths, opcode and state encodings and reset constants shared by the core
   units and the testbench; import with cpu6809_pkg::* in the module header */
`default_nettype none

package cpu6809_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int addr_w = 16;
  localparam int data_w = 8;

  // Big-endian start vector, high byte here and low byte at the next address
  localparam logic [addr_w-1:0] reset_vector_addr = 16'hfffe;

  // E, F and I set out of reset, arithmetic flags clear
  localparam logic [data_w-1:0] cc_reset = 8'b1101_0000;

  // CC bit offsets
  localparam int cc_c = 0;  // Carry
  localparam int cc_v = 1;  // Overflow
  localparam int cc_z = 2;  // Zero
  localparam int cc_n = 3;  // Negative
  localparam int cc_h = 5;  // Half carry

  // --------------------------------------------------------------------------
  // Opcodes kept in this core, encoded as on the bus
  // --------------------------------------------------------------------------
  typedef enum logic [data_w-1:0] {
    // Inherent, A then B
    op_clra    = 8'h4f,
    op_clrb    = 8'h5f,
    op_inca    = 8'h4c,
    op_incb    = 8'h5c,
    op_asla    = 8'h48,
    op_aslb    = 8'h58,
    op_rola    = 8'h49,
    op_rolb    = 8'h59,
    op_asra    = 8'h47,
    op_asrb    = 8'h57,
    op_lsra    = 8'h44,
    op_lsrb    = 8'h54,
    op_rora    = 8'h46,
    op_rorb    = 8'h56,
    op_coma    = 8'h43,
    op_comb    = 8'h53,
    // Immediate loads
    op_lda     = 8'h86,
    op_ldb     = 8'hc6,
    op_ldd     = 8'hcc,
    // Extended stores
    op_sta     = 8'hb7,
    op_stb     = 8'hf7,
    // Short branches on carry
    op_bcs     = 8'h25,
    op_bcc     = 8'h24,
    // Anything else runs as a one-byte NOP
    op_illegal = 8'h01
  } opcode_e;

  // Fetch sequencer: bus wait, opcode, first and second following byte
  typedef enum logic [1:0] {fetch_wait, fetch_ir, fetch_b1, fetch_b2} fetch_state_e;

  // Load/store unit: vector high byte, vector low byte, idle, write
  typedef enum logic [1:0] {lsu_vec_hi, lsu_vec_lo, lsu_idle, lsu_store} lsu_state_e;

endpackage

`default_nettype wire

// File: src/fetch_sequencer.sv
/* Instruction fetch FSM, one byte per cycle; issues execute, branch and
   store requests once the last byte of an instruction is on the bus */
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer
  import cpu6809_pkg::*;
(
  input  logic              clk,
  input  logic              reset_b,
  input  logic [data_w-1:0] data_in,
  input  logic              lsu_busy,
  input  logic              cc_c,
  output logic              pc_inc,
  output logic              branch_taken,
  output logic [data_w-1:0] offset,
  output logic              exec_strobe,
  output opcode_e           opcode,
  output logic [data_w-1:0] operand_hi,
  output logic [data_w-1:0] operand_lo,
  output logic              store_req,
  output logic [addr_w-1:0] store_addr,
  output logic              store_sel
);

  fetch_state_e      state_q;
  fetch_state_e      state_nxt;
  opcode_e           op_dec;     // Opcode byte on the bus, decoded
  opcode_e           op_q;       // Opcode of the instruction in progress
  logic [data_w-1:0] b1_q;       // First following byte
  logic [1:0]        op_len;     // Bytes after the opcode
  logic              issue;

  // --------------------------------------------------------------------------
  // Decode and addressing mode
  // --------------------------------------------------------------------------
  always_comb begin
    case (data_in)
      op_clra, op_clrb, op_inca, op_incb, op_asla, op_aslb, op_rola, op_rolb,
      op_asra, op_asrb, op_lsra, op_lsrb, op_rora, op_rorb, op_coma, op_comb,
      op_lda, op_ldb, op_ldd, op_sta, op_stb, op_bcs, op_bcc:
        op_dec = opcode_e'(data_in);
      default:
        op_dec = op_illegal;
    endcase
    // Immediate 8-bit and branch take one byte, LDD and extended two
    case (op_dec)
      op_lda, op_ldb, op_bcs, op_bcc: op_len = 2'd1;
      op_ldd, op_sta, op_stb:         op_len = 2'd2;
      default:                        op_len = 2'd0;
    endcase
  end

  always_comb begin
    case (state_q)
      fetch_wait: state_nxt = lsu_busy ? fetch_wait : fetch_ir;
      fetch_ir:   state_nxt = (op_len == 2'd0) ? fetch_ir : fetch_b1;
      fetch_b1:   state_nxt = (op_q inside {op_ldd, op_sta, op_stb}) ? fetch_b2 : fetch_ir;
      // Stores hand the bus to the LSU
      default:    state_nxt = store_req ? fetch_wait : fetch_ir;
    endcase
  end

  // Execute goes out on the last byte of inherent and load instructions
  assign issue = ((state_q == fetch_ir) && (op_len == 2'd0)) ||
                 ((state_q == fetch_b1) && (op_q inside {op_lda, op_ldb})) ||
                 ((state_q == fetch_b2) && (op_q == op_ldd));

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q     <= fetch_wait;
      exec_strobe <= 1'b0;
      opcode      <= op_illegal;
    end else begin
      state_q     <= state_nxt;
      exec_strobe <= issue;
      if (issue) begin
        opcode <= (state_q == fetch_ir) ? op_dec : op_q;
      end
    end
  end

  // Instruction bytes
  always_ff @(posedge clk) begin
    if (state_q == fetch_ir) begin
      op_q <= op_dec;
    end
    if (state_q == fetch_b1) begin
      b1_q <= data_in;
    end
    // LDD takes its high byte from b1, 8-bit loads straight off the bus
    if (issue && state_q == fetch_b1) begin
      operand_hi <= data_in;
    end
    if (issue && state_q == fetch_b2) begin
      operand_hi <= b1_q;
      operand_lo <= data_in;
    end
  end

  // --------------------------------------------------------------------------
  // Bus-side requests, all combinational
  // --------------------------------------------------------------------------
  assign pc_inc       = (state_q != fetch_wait);
  assign offset       = data_in;
  assign branch_taken = (state_q == fetch_b1) &&
                        (((op_q == op_bcs) && cc_c) || ((op_q == op_bcc) && !cc_c));
  assign store_req    = (state_q == fetch_b2) && (op_q inside {op_sta, op_stb});
  assign store_addr   = {b1_q, data_in};
  assign store_sel    = (op_q == op_stb);

endmodule

`default_nettype wire

// File: src/load_store_unit.sv
/* Data-side bus master; reads the reset vector after reset and performs
   single-byte writes of A or B for the extended stores */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
  import cpu6809_pkg::*;
#(
  parameter logic [addr_w-1:0] reset_vector_addr_p = reset_vector_addr
) (
  input  logic              clk,
  input  logic              reset_b,
  input  logic [data_w-1:0] data_in,
  input  logic              store_req,
  input  logic [addr_w-1:0] store_addr,
  input  logic              store_sel,
  input  logic [data_w-1:0] a_q,
  input  logic [data_w-1:0] b_q,
  output logic              lsu_busy,
  output logic [addr_w-1:0] lsu_addr,
  output logic              data_rw_n,
  output logic [data_w-1:0] data_out,
  output logic              vec_load,
  output logic [addr_w-1:0] vec_value
);

  lsu_state_e        state_q;
  lsu_state_e        state_nxt;
  logic [data_w-1:0] vec_hi_q;      // Staged high byte of the vector
  logic [addr_w-1:0] store_addr_q;
  logic              store_sel_q;   // 1 selects B

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  always_comb begin
    case (state_q)
      lsu_vec_hi: state_nxt = lsu_vec_lo;
      lsu_vec_lo: state_nxt = lsu_idle;
      lsu_idle:   state_nxt = store_req ? lsu_store : lsu_idle;
      default:    state_nxt = lsu_idle;   // Single write cycle
    endcase
  end

  // Vector read starts straight out of reset
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q <= lsu_vec_hi;
    end else begin
      state_q <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == lsu_vec_hi) begin
      vec_hi_q <= data_in;
    end
    if (store_req) begin
      store_addr_q <= store_addr;
      store_sel_q  <= store_sel;
    end
  end

  // --------------------------------------------------------------------------
  // Bus drive
  // --------------------------------------------------------------------------
  always_comb begin
    case (state_q)
      lsu_vec_hi: lsu_addr = reset_vector_addr_p;
      lsu_vec_lo: lsu_addr = reset_vector_addr_p + 1'b1;
      default:    lsu_addr = store_addr_q;
    endcase
  end

  assign lsu_busy  = (state_q != lsu_idle);
  assign data_rw_n = (state_q != lsu_store);
  assign data_out  = (state_q == lsu_store) ? (store_sel_q ? b_q : a_q) : '0;

  // Low byte comes straight off the bus
  assign vec_load  = (state_q == lsu_vec_lo);
  assign vec_value = {vec_hi_q, data_in};

endmodule

`default_nettype wire

// File: src/program_counter.sv
/* 16-bit program counter; loads the reset vector, steps on each fetched
   byte and adds the sign-extended offset on a taken branch */
`timescale 1ns/1ps
`default_nettype none

module program_counter
  import cpu6809_pkg::*;
(
  input  logic              clk,
  input  logic              reset_b,
  input  logic              pc_inc,
  input  logic              branch_taken,
  input  logic [data_w-1:0] offset,
  input  logic              vec_load,
  input  logic [addr_w-1:0] vec_value,
  output logic [addr_w-1:0] pc
);

  logic [addr_w-1:0] pc_plus1;
  logic [addr_w-1:0] offset_sext;

  // Address of the next byte
  assign pc_plus1 = pc + 1'b1;

  // Short branch reach is -128 to +127 from the following instruction
  assign offset_sext = {{(addr_w - data_w){offset[data_w-1]}}, offset};

  // --------------------------------------------------------------------------
  // Counter update
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      pc <= '0;
    end else if (vec_load) begin
      pc <= vec_value;
    end else if (branch_taken) begin
      // Offset byte is consumed in the same cycle
      pc <= pc_plus1 + offset_sext;
    end else if (pc_inc) begin
      pc <= pc_plus1;
    end
  end

endmodule

`default_nettype wire
